// ==== logic/pinmux_pkg.sv ====
/*
 * Pad multiplexer shared definitions
 * Widths, register word map, pad assignments and the structs that
 * carry the register bus and the pad configuration between blocks
 */
package pinmux_pkg;

  // --------------------------------------------------------------------
  // Widths and counts
  // --------------------------------------------------------------------
  localparam int NUM_PADS  = 16;
  localparam int NUM_PWM   = 4;
  localparam int DATA_W    = 32;
  localparam int BE_W      = DATA_W / 8;
  localparam int ADDR_W    = 4;
  localparam int PWM_CNT_W = 16;
  localparam int PWM_IDX_W = $clog2(NUM_PWM);
  localparam int DIV_W     = 10;
  // 1 us ticks per 1 ms tick
  localparam int US_PER_MS = 1000;
  localparam int MS_CNT_W  = $clog2(US_PER_MS);
  // PWM enables plus one UART enable
  localparam int FUNC_W        = NUM_PWM + 1;
  localparam int FUNC_UART_BIT = NUM_PWM;

  // --------------------------------------------------------------------
  // Register word addresses
  // --------------------------------------------------------------------
  localparam logic [ADDR_W-1:0] ADDR_GPIO_OUT = 4'd0;
  localparam logic [ADDR_W-1:0] ADDR_GPIO_DIR = 4'd1;
  localparam logic [ADDR_W-1:0] ADDR_FUNC_SEL = 4'd2;
  // Read only
  localparam logic [ADDR_W-1:0] ADDR_GPIO_IN  = 4'd3;
  localparam logic [ADDR_W-1:0] ADDR_TICK_DIV = 4'd4;
  // Channel k at base + k
  localparam logic [ADDR_W-1:0] ADDR_PWM_BASE = 4'd8;

  // Divider after reset, 10 MHz clock gives 1 us
  localparam logic [DIV_W-1:0] TICK_DIV_RST = 10'd9;

  // --------------------------------------------------------------------
  // Pad assignments
  // --------------------------------------------------------------------
  localparam int PAD_UART_RX  = 1;
  localparam int PAD_UART_TX  = 2;
  localparam int PAD_PWM_BASE = 4;

  // --------------------------------------------------------------------
  // Bus and configuration structs
  // --------------------------------------------------------------------
  typedef struct packed {
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } reg_rsp_t;

  // Low length in the upper half word
  typedef struct packed {
    logic [PWM_CNT_W-1:0] low;
    logic [PWM_CNT_W-1:0] high;
  } pwm_cfg_t;

  typedef struct packed {
    logic [NUM_PADS-1:0] gpio_out;
    logic [NUM_PADS-1:0] gpio_dir;
    logic [NUM_PWM-1:0]  pwm_enb;
    logic                uart_enb;
  } pad_cfg_t;

endpackage

// ==== logic/pinmux_regs.sv ====
/*
 * Pad multiplexer register bank
 * Valid/ready request bus with a one-entry response slot,
 * byte-enabled writes to GPIO, function select, divider and PWM words,
 * and a two-flop synchronizer on the pad inputs for GPIO reads
 */
module pinmux_regs (
  input  logic                                           mclk,
  input  logic                                           reset_i,
  // Request side
  input  pinmux_pkg::reg_req_t                           req_i,
  input  logic                                           req_valid_i,
  output logic                                           req_ready_o,
  // Response side
  output pinmux_pkg::reg_rsp_t                           rsp_o,
  output logic                                           rsp_valid_o,
  input  logic                                           rsp_ready_i,
  // Raw pad levels
  input  logic [pinmux_pkg::NUM_PADS-1:0]                pad_in_i,
  // Configuration out
  output pinmux_pkg::pad_cfg_t                           pad_cfg_o,
  output logic [pinmux_pkg::DIV_W-1:0]                   tick_div_o,
  output pinmux_pkg::pwm_cfg_t [pinmux_pkg::NUM_PWM-1:0] pwm_cfg_o
);

  import pinmux_pkg::*;

  // Configuration state
  logic [NUM_PADS-1:0]           gpio_out_q;
  logic [NUM_PADS-1:0]           gpio_dir_q;
  logic [FUNC_W-1:0]             func_sel_q;
  logic [DIV_W-1:0]              tick_div_q;
  pwm_cfg_t [NUM_PWM-1:0]        pwm_cfg_q;

  // Pad input synchronizer
  logic [NUM_PADS-1:0]           pad_meta_q;
  logic [NUM_PADS-1:0]           pad_sync_q;

  // Decode and data paths
  logic                          accept;
  logic                          pwm_hit;
  logic [PWM_IDX_W-1:0]          pwm_idx;
  logic [DATA_W-1:0]             rd_data;
  logic [DATA_W-1:0]             wr_data;

  // Old word with the enabled bytes replaced
  function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] old_val,
                                                 input logic [DATA_W-1:0] new_val,
                                                 input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // --------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------
  // One request in flight, so ready only while the slot is empty
  assign req_ready_o = ~rsp_valid_o;
  assign accept      = req_valid_i & req_ready_o;

  // PWM words sit in a contiguous window
  assign pwm_hit = (req_i.addr >= ADDR_PWM_BASE) &&
                   (req_i.addr <  ADDR_PWM_BASE + ADDR_W'(NUM_PWM));
  assign pwm_idx = PWM_IDX_W'(req_i.addr - ADDR_PWM_BASE);

  // --------------------------------------------------------------------
  // Read mux
  // --------------------------------------------------------------------
  // Also the old value for the byte merge on writes
  always_comb begin
    rd_data = '0;
    case (req_i.addr)
      ADDR_GPIO_OUT: rd_data = DATA_W'(gpio_out_q);
      ADDR_GPIO_DIR: rd_data = DATA_W'(gpio_dir_q);
      ADDR_FUNC_SEL: rd_data = DATA_W'(func_sel_q);
      ADDR_GPIO_IN:  rd_data = DATA_W'(pad_sync_q);
      ADDR_TICK_DIV: rd_data = DATA_W'(tick_div_q);
      default: begin
        if (pwm_hit) begin
          rd_data = pwm_cfg_q[pwm_idx];
        end
      end
    endcase
  end

  assign wr_data = be_merge(rd_data, req_i.wdata, req_i.be);

  // --------------------------------------------------------------------
  // Register writes
  // --------------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      gpio_out_q <= '0;
      gpio_dir_q <= '0;
      func_sel_q <= '0;
      tick_div_q <= TICK_DIV_RST;
      pwm_cfg_q  <= '0;
    end else if (accept && req_i.wr) begin
      case (req_i.addr)
        ADDR_GPIO_OUT: gpio_out_q <= wr_data[NUM_PADS-1:0];
        ADDR_GPIO_DIR: gpio_dir_q <= wr_data[NUM_PADS-1:0];
        ADDR_FUNC_SEL: func_sel_q <= wr_data[FUNC_W-1:0];
        ADDR_TICK_DIV: tick_div_q <= wr_data[DIV_W-1:0];
        // GPIO_IN and holes drop the write
        default: begin
          if (pwm_hit) begin
            pwm_cfg_q[pwm_idx] <= wr_data;
          end
        end
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Response slot
  // --------------------------------------------------------------------
  // Filled on accept, drained when the consumer takes it
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
    end else if (accept) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  // Held while the slot waits; writes answer zero
  always_ff @(posedge mclk) begin
    if (accept) begin
      rsp_o.rdata <= req_i.wr ? '0 : rd_data;
    end
  end

  // Two stages, level visible to reads two cycles later
  always_ff @(posedge mclk) begin
    pad_meta_q <= pad_in_i;
    pad_sync_q <= pad_meta_q;
  end

  // Outputs to the datapath
  assign pad_cfg_o.gpio_out = gpio_out_q;
  assign pad_cfg_o.gpio_dir = gpio_dir_q;
  assign pad_cfg_o.pwm_enb  = func_sel_q[NUM_PWM-1:0];
  assign pad_cfg_o.uart_enb = func_sel_q[FUNC_UART_BIT];
  assign tick_div_o         = tick_div_q;
  assign pwm_cfg_o          = pwm_cfg_q;

endmodule

// ==== logic/tick_gen.sv ====
/*
 * Tick generator
 * Divides mclk down to a 1 us pulse with a programmable divider,
 * then counts 1 us pulses into a 1 ms pulse
 */
module tick_gen (
  input  logic                         mclk,
  input  logic                         reset_i,
  input  logic [pinmux_pkg::DIV_W-1:0] tick_div_i,
  output logic                         tick_1us_o,
  output logic                         tick_1ms_o
);

  import pinmux_pkg::*;

  logic [DIV_W-1:0]    us_cnt;
  logic                us_wrap;
  logic [MS_CNT_W-1:0] ms_cnt;
  logic                ms_last;

  // --------------------------------------------------------------------
  // 1 us divider
  // --------------------------------------------------------------------
  // Compare with >= so a smaller new divider restarts the count
  assign us_wrap = (us_cnt >= tick_div_i);

  // Counts 0..div, one pulse per div+1 cycles
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      us_cnt     <= '0;
      tick_1us_o <= 1'b0;
    end else begin
      tick_1us_o <= us_wrap;
      if (us_wrap) begin
        us_cnt <= '0;
      end else begin
        us_cnt <= us_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------
  // 1 ms counter
  // --------------------------------------------------------------------
  assign ms_last = (ms_cnt == MS_CNT_W'(US_PER_MS - 1));

  always_ff @(posedge mclk) begin
    if (reset_i) begin
      ms_cnt <= '0;
    end else if (tick_1us_o) begin
      ms_cnt <= ms_last ? '0 : ms_cnt + 1'b1;
    end
  end

  // Coincides with every thousandth 1 us pulse
  assign tick_1ms_o = tick_1us_o & ms_last;

endmodule

// ==== logic/pwm_gen.sv ====
/*
 * PWM channel
 * High and low phase lengths counted in 1 ms ticks,
 * starts high on enable and idles low when disabled
 */
module pwm_gen (
  input  logic                 mclk,
  input  logic                 reset_i,
  input  logic                 tick_1ms_i,
  input  logic                 enb_i,
  input  pinmux_pkg::pwm_cfg_t cfg_i,
  output logic                 wfm_o
);

  import pinmux_pkg::*;

  logic                 run_q;
  logic [PWM_CNT_W-1:0] cnt_q;
  logic [PWM_CNT_W-1:0] cfg_len;
  logic [PWM_CNT_W-1:0] phase_len;
  logic                 phase_done;

  // --------------------------------------------------------------------
  // Phase length
  // --------------------------------------------------------------------
  // Current phase picks high or low length
  assign cfg_len = wfm_o ? cfg_i.high : cfg_i.low;

  // Zero length behaves as one tick
  assign phase_len = (cfg_len == '0) ? PWM_CNT_W'(1) : cfg_len;

  // >= so a shortened phase ends on the next tick
  assign phase_done = (cnt_q >= phase_len - 1'b1);

  // --------------------------------------------------------------------
  // Phase counter
  // --------------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      run_q <= 1'b0;
      wfm_o <= 1'b0;
      cnt_q <= '0;
    end else if (!enb_i) begin
      // Parked low, counter cleared
      run_q <= 1'b0;
      wfm_o <= 1'b0;
      cnt_q <= '0;
    end else if (!run_q) begin
      // First enabled cycle enters the high phase
      run_q <= 1'b1;
      wfm_o <= 1'b1;
      cnt_q <= '0;
    end else if (tick_1ms_i) begin
      if (phase_done) begin
        // Flip phase and reload
        wfm_o <= ~wfm_o;
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== logic/pad_mux.sv ====
/*
 * Pad multiplexer
 * Picks the driver of each pad by priority: enabled UART or PWM
 * function first, then GPIO output when the direction bit is set,
 * otherwise the pad stays an input. Purely combinational
 */
module pad_mux (
  input  pinmux_pkg::pad_cfg_t                 pad_cfg_i,
  input  logic [pinmux_pkg::NUM_PWM-1:0]       pwm_wfm_i,
  input  logic                                 uart_txd_i,
  input  logic [pinmux_pkg::NUM_PADS-1:0]      pad_in_i,
  output logic [pinmux_pkg::NUM_PADS-1:0]      pad_out_o,
  output logic [pinmux_pkg::NUM_PADS-1:0]      pad_oen_o,
  output logic                                 uart_rxd_o
);

  import pinmux_pkg::*;

  // --------------------------------------------------------------------
  // Output data and output enable
  // --------------------------------------------------------------------
  // oen is active low, 1 leaves the pad as input
  always_comb begin
    // Lowest priority, GPIO per direction bit
    for (int p = 0; p < NUM_PADS; p++) begin
      pad_out_o[p] = pad_cfg_i.gpio_dir[p] & pad_cfg_i.gpio_out[p];
      pad_oen_o[p] = ~pad_cfg_i.gpio_dir[p];
    end

    // PWM channel k owns pad base + k
    for (int k = 0; k < NUM_PWM; k++) begin
      if (pad_cfg_i.pwm_enb[k]) begin
        pad_out_o[PAD_PWM_BASE + k] = pwm_wfm_i[k];
        pad_oen_o[PAD_PWM_BASE + k] = 1'b0;
      end
    end

    // UART takes both its pads
    if (pad_cfg_i.uart_enb) begin
      // TXD driven out
      pad_out_o[PAD_UART_TX] = uart_txd_i;
      pad_oen_o[PAD_UART_TX] = 1'b0;
      // RXD forced to input, whatever GPIO dir says
      pad_out_o[PAD_UART_RX] = 1'b0;
      pad_oen_o[PAD_UART_RX] = 1'b1;
    end
  end

  // --------------------------------------------------------------------
  // Input routing
  // --------------------------------------------------------------------
  // Held low while the UART is off
  assign uart_rxd_o = pad_cfg_i.uart_enb & pad_in_i[PAD_UART_RX];

endmodule

// ==== logic/pinmux_top.sv ====
/*
 * Pad multiplexer top level
 * Register bank, tick generator, four PWM channels and the pad mux
 * sharing 16 pads between GPIO, one UART and the PWM outputs
 */
module pinmux_top (
  input  logic                            mclk,
  input  logic                            reset_i,
  // Register bus
  input  pinmux_pkg::reg_req_t            req_i,
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  output pinmux_pkg::reg_rsp_t            rsp_o,
  output logic                            rsp_valid_o,
  input  logic                            rsp_ready_i,
  // UART core side
  input  logic                            uart_txd_i,
  output logic                            uart_rxd_o,
  // Pads
  input  logic [pinmux_pkg::NUM_PADS-1:0] pad_in_i,
  output logic [pinmux_pkg::NUM_PADS-1:0] pad_out_o,
  output logic [pinmux_pkg::NUM_PADS-1:0] pad_oen_o
);

  import pinmux_pkg::*;

  pad_cfg_t               pad_cfg;
  logic [DIV_W-1:0]       tick_div;
  pwm_cfg_t [NUM_PWM-1:0] pwm_cfg;
  logic                   tick_1ms;
  logic [NUM_PWM-1:0]     pwm_wfm;

  // --------------------------------------------------------------------
  // Configuration registers
  // --------------------------------------------------------------------
  pinmux_regs u_regs (
    .mclk        (mclk),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .pad_in_i    (pad_in_i),
    .pad_cfg_o   (pad_cfg),
    .tick_div_o  (tick_div),
    .pwm_cfg_o   (pwm_cfg)
  );

  // 1 us pulse only feeds the 1 ms counter inside
  tick_gen u_tick (
    .mclk       (mclk),
    .reset_i    (reset_i),
    .tick_div_i (tick_div),
    .tick_1us_o (),
    .tick_1ms_o (tick_1ms)
  );

  // --------------------------------------------------------------------
  // PWM channels
  // --------------------------------------------------------------------
  for (genvar k = 0; k < NUM_PWM; k++) begin : g_pwm
    pwm_gen u_pwm (
      .mclk       (mclk),
      .reset_i    (reset_i),
      .tick_1ms_i (tick_1ms),
      .enb_i      (pad_cfg.pwm_enb[k]),
      .cfg_i      (pwm_cfg[k]),
      .wfm_o      (pwm_wfm[k])
    );
  end

  // Pad routing
  pad_mux u_pad_mux (
    .pad_cfg_i  (pad_cfg),
    .pwm_wfm_i  (pwm_wfm),
    .uart_txd_i (uart_txd_i),
    .pad_in_i   (pad_in_i),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o),
    .uart_rxd_o (uart_rxd_o)
  );

endmodule

// ==== bench/tb_pinmux.sv ====
/*
 * Testbench for the pad multiplexer
 * Drives the register bus on the falling clock edge and checks
 * register access, GPIO and UART routing, PWM phase lengths
 * and response back-pressure
 */
module tb_pinmux;

  timeunit 1ns;
  timeprecision 100ps;

  import pinmux_pkg::*;

  // Divider of 1 gives 2 cycles per us and 2000 per ms
  localparam int MS_CYCLES  = 2000;
  // High 2 ms plus low 1 ms
  localparam int PWM_PERIOD = 3 * MS_CYCLES;
  // About twice the PWM and register test length
  localparam int TIMEOUT_LIMIT = 6 * PWM_PERIOD + 2 * MS_CYCLES;
  localparam int PWM_PAD       = PAD_PWM_BASE + 1;
  localparam logic [ADDR_W-1:0] ADDR_HOLE = 4'd5;

  logic                mclk;
  logic                reset_i;
  reg_req_t            req_i;
  logic                req_valid_i;
  logic                req_ready_o;
  reg_rsp_t            rsp_o;
  logic                rsp_valid_o;
  logic                rsp_ready_i;
  logic                uart_txd_i;
  logic                uart_rxd_o;
  logic [NUM_PADS-1:0] pad_in_i;
  logic [NUM_PADS-1:0] pad_out_o;
  logic [NUM_PADS-1:0] pad_oen_o;

  int          seed;
  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  int          cycle_cnt = 0;
  // Expected register contents
  logic [31:0] model [16];

  pinmux_top UUT (.*);

  // --------------------------------------------------------------------
  // Clock, cycle count and timeout
  // --------------------------------------------------------------------
  initial begin
    mclk = 1'b0;
    forever #4 mclk = ~mclk;
  end

  always @(posedge mclk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_LIMIT);
    $display("Timeout: the run was still busy after %0d cycles", TIMEOUT_LIMIT);
    $display("Test failed");
    $finish;
  end

  // --------------------------------------------------------------------
  // Bus protocol checks
  // --------------------------------------------------------------------
  // Ready exactly while no response is pending
  ready_rule: assert property (@(posedge mclk) disable iff (reset_i)
                               req_ready_o == !rsp_valid_o)
    else flag_error("req_ready_o disagrees with the pending response");

  // Response one cycle after acceptance
  rsp_latency: assert property (@(posedge mclk) disable iff (reset_i)
                                (req_valid_i && req_ready_o) |=> rsp_valid_o)
    else flag_error("no response one cycle after acceptance");

  // Slot frozen under back-pressure
  rsp_hold: assert property (@(posedge mclk) disable iff (reset_i)
                             (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
    else flag_error("response changed while rsp_ready_i was low");

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------
  task automatic flag_error(input string msg);
    err_cnt++;
    $display("** Error at %0d ns: %s", $time, msg);
  endtask

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  // Implemented bits of each writable word
  function automatic logic [31:0] reg_mask(input logic [ADDR_W-1:0] addr);
    case (addr)
      ADDR_GPIO_OUT, ADDR_GPIO_DIR: reg_mask = 32'h0000_ffff;
      ADDR_FUNC_SEL:                reg_mask = 32'h0000_001f;
      ADDR_TICK_DIV:                reg_mask = 32'h0000_03ff;
      4'd8, 4'd9, 4'd10, 4'd11:     reg_mask = 32'hffff_ffff;
      default:                      reg_mask = 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] byte_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  be);
    logic [31:0] keep;
    keep = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    byte_merge = (old_val & ~keep) | (new_val & keep);
  endfunction

  // One request with waits for ready and for the response
  task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            output logic [31:0] rdata);
    int wait_cnt;
    @(negedge mclk);
    req_i.wr    = wr;
    req_i.addr  = addr;
    req_i.wdata = wdata;
    req_i.be    = be;
    req_valid_i = 1'b1;
    while (!req_ready_o) @(negedge mclk);
    // Accepted on the rising edge in between
    @(negedge mclk);
    req_valid_i = 1'b0;
    wait_cnt = 0;
    while (!rsp_valid_o) begin
      @(negedge mclk);
      wait_cnt++;
    end
    assert (wait_cnt == 0)
      else flag_error($sformatf("response %0d cycles late", wait_cnt));
    rdata = rsp_o.rdata;
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] rdata;
    bus_access(1'b1, addr, data, be, rdata);
    assert (rdata == 32'h0)
      else flag_error($sformatf("write response %h, expected zero", rdata));
    model[addr] = byte_merge(model[addr], data, be) & reg_mask(addr);
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'h0, 4'h0, data);
  endtask

  task automatic end_test(input string name, input int start);
    tests_run++;
    if (err_cnt != start) begin
      tests_failed++;
      $display("Test %0d, %s: FAILED with %0d errors", tests_run, name, err_cnt - start);
    end else begin
      $display("Test %0d, %s: ok", tests_run, name);
    end
  endtask

  // --------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------
  task automatic test_reset_regs();
    logic [31:0]       r;
    logic [31:0]       b;
    logic [31:0]       got;
    logic [ADDR_W-1:0] addr;
    assert (pad_oen_o == '1 && rsp_valid_o == 1'b0 && req_ready_o == 1'b1)
      else flag_error($sformatf("reset state oen %h rsp_valid %b", pad_oen_o, rsp_valid_o));
    bus_read(ADDR_TICK_DIV, got);
    assert (got == 32'd9) else flag_error($sformatf("divider reads %0d, expected 9", got));
    for (int i = 0; i < 24; i++) begin
      r = rand32();
      b = rand32();
      case (r % 32'd7)
        32'd0:   addr = ADDR_GPIO_OUT;
        32'd1:   addr = ADDR_GPIO_DIR;
        32'd2:   addr = ADDR_FUNC_SEL;
        default: addr = ADDR_PWM_BASE + {2'b00, b[5:4]};
      endcase
      bus_write(addr, rand32(), b[3:0]);
      bus_read(addr, got);
      assert (got == model[addr])
        else flag_error($sformatf("addr %0d reads %h, expected %h", addr, got, model[addr]));
    end
    // Hole reads zero and the read-only word ignores writes
    bus_read(ADDR_HOLE, got);
    assert (got == 32'h0) else flag_error($sformatf("unmapped read %h", got));
    bus_write(ADDR_GPIO_IN, 32'hffff_ffff, 4'hf);
    bus_read(ADDR_GPIO_IN, got);
    assert (got == 32'h0) else flag_error($sformatf("GPIO_IN took a write, reads %h", got));
    bus_write(ADDR_FUNC_SEL, 32'h0, 4'hf);
  endtask

  task automatic test_gpio_out();
    logic [31:0] out_v;
    logic [31:0] dir_v;
    for (int i = 0; i < 8; i++) begin
      out_v = rand32();
      dir_v = rand32();
      bus_write(ADDR_GPIO_OUT, out_v, 4'hf);
      bus_write(ADDR_GPIO_DIR, dir_v, 4'hf);
      @(negedge mclk);
      assert (pad_oen_o == ~dir_v[15:0])
        else flag_error($sformatf("oen %h, expected %h", pad_oen_o, ~dir_v[15:0]));
      assert ((pad_out_o & dir_v[15:0]) == (out_v[15:0] & dir_v[15:0]))
        else flag_error($sformatf("pad_out %h, gpio_out %h", pad_out_o, out_v[15:0]));
    end
  endtask

  task automatic test_gpio_in();
    logic [31:0] r;
    logic [31:0] got;
    for (int i = 0; i < 8; i++) begin
      r = rand32();
      @(negedge mclk);
      pad_in_i = r[15:0];
      repeat (3) @(negedge mclk);
      bus_read(ADDR_GPIO_IN, got);
      assert (got == {16'h0, r[15:0]})
        else flag_error($sformatf("GPIO_IN reads %h, expected %h", got, r[15:0]));
    end
  endtask

  task automatic test_uart();
    logic [31:0] out_v;
    logic [31:0] dir_v;
    logic [31:0] r;
    out_v = rand32();
    // RX pad set as GPIO output so the UART override shows
    dir_v = rand32() | 32'h2;
    bus_write(ADDR_GPIO_OUT, out_v, 4'hf);
    bus_write(ADDR_GPIO_DIR, dir_v, 4'hf);
    bus_write(ADDR_FUNC_SEL, 32'h10, 4'h1);
    for (int i = 0; i < 12; i++) begin
      r = rand32();
      uart_txd_i = r[0];
      pad_in_i   = r[31:16];
      @(negedge mclk);
      assert (pad_out_o[PAD_UART_TX] == uart_txd_i && pad_oen_o[PAD_UART_TX] == 1'b0)
        else flag_error("TX pad does not follow uart_txd_i");
      assert (pad_oen_o[PAD_UART_RX] == 1'b1 && uart_rxd_o == pad_in_i[PAD_UART_RX])
        else flag_error("RX pad not routed as input to uart_rxd_o");
    end
    bus_write(ADDR_FUNC_SEL, 32'h0, 4'h1);
    pad_in_i = 16'hffff;
    @(negedge mclk);
    assert (uart_rxd_o == 1'b0) else flag_error("uart_rxd_o high with the UART off");
    assert (pad_oen_o == ~dir_v[15:0] &&
            (pad_out_o & dir_v[15:0]) == (out_v[15:0] & dir_v[15:0]))
      else flag_error("UART pads did not return to GPIO");
  endtask

  // Cycles spent at one level as counted on falling edges
  task automatic measure_phase(input logic level, input int expected);
    int len;
    len = 0;
    while (pad_out_o[PWM_PAD] == level) begin
      @(negedge mclk);
      len++;
    end
    assert (len == expected)
      else flag_error($sformatf("PWM %s phase %0d cycles, expected %0d",
                                level ? "high" : "low", len, expected));
  endtask

  task automatic test_pwm();
    bus_write(ADDR_TICK_DIV, 32'd1, 4'h3);
    bus_write(ADDR_GPIO_OUT, 32'h0, 4'hf);
    bus_write(ADDR_GPIO_DIR, 32'h1 << PWM_PAD, 4'hf);
    // Channel 1 with high 2 ms and low 1 ms
    bus_write(ADDR_PWM_BASE + 4'd1, {16'd1, 16'd2}, 4'hf);
    bus_write(ADDR_FUNC_SEL, 32'h02, 4'h1);
    @(negedge mclk);
    assert (pad_oen_o[PWM_PAD] == 1'b0 && pad_out_o[PWM_PAD] == 1'b1)
      else flag_error("PWM pad not driven high after enable");
    // First high phase depends on where the 1 ms count stood
    while (pad_out_o[PWM_PAD]) @(negedge mclk);
    measure_phase(1'b0, MS_CYCLES);
    measure_phase(1'b1, 2 * MS_CYCLES);
    measure_phase(1'b0, MS_CYCLES);
    measure_phase(1'b1, 2 * MS_CYCLES);
    bus_write(ADDR_FUNC_SEL, 32'h0, 4'h1);
    @(negedge mclk);
    assert (pad_oen_o[PWM_PAD] == 1'b0 && pad_out_o[PWM_PAD] == 1'b0)
      else flag_error("PWM pad did not return to GPIO low");
    bus_write(ADDR_GPIO_OUT, 32'h1 << PWM_PAD, 4'hf);
    @(negedge mclk);
    assert (pad_out_o[PWM_PAD] == 1'b1) else flag_error("PWM pad ignores GPIO high");
  endtask

  task automatic test_backpressure();
    logic [31:0] val;
    logic [31:0] got;
    val = rand32();
    bus_write(ADDR_GPIO_OUT, val, 4'hf);
    @(negedge mclk);
    rsp_ready_i = 1'b0;
    bus_read(ADDR_GPIO_OUT, got);
    assert (got == {16'h0, val[15:0]})
      else flag_error($sformatf("read %h, expected %h", got, val[15:0]));
    repeat (6) begin
      @(negedge mclk);
      assert (rsp_valid_o && rsp_o.rdata == got && !req_ready_o)
        else flag_error("response slot not held under back-pressure");
    end
    rsp_ready_i = 1'b1;
    @(negedge mclk);
    assert (!rsp_valid_o && req_ready_o) else flag_error("slot not drained after rsp_ready_i");
  endtask

  // --------------------------------------------------------------------
  // Sequence
  // --------------------------------------------------------------------
  initial begin
    int start;
    seed         = 40;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_i      = 1'b1;
    req_i        = '0;
    req_valid_i  = 1'b0;
    rsp_ready_i  = 1'b1;
    uart_txd_i   = 1'b0;
    pad_in_i     = '0;
    foreach (model[i]) model[i] = 32'h0;
    model[ADDR_TICK_DIV] = 32'd9;
    repeat (3) @(posedge mclk);
    @(negedge mclk);
    reset_i = 1'b0;

    start = err_cnt;
    test_reset_regs();
    end_test("reset state and register read-back", start);
    start = err_cnt;
    test_gpio_out();
    end_test("GPIO output", start);
    start = err_cnt;
    test_gpio_in();
    end_test("GPIO input", start);
    start = err_cnt;
    test_uart();
    end_test("UART mux", start);
    start = err_cnt;
    test_pwm();
    end_test("PWM phases", start);
    start = err_cnt;
    test_backpressure();
    end_test("response back-pressure", start);

    $display("Summary: %0d tests run, %0d failed, %0d errors",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
logic/pinmux_pkg.sv
logic/pinmux_regs.sv
logic/tick_gen.sv
logic/pwm_gen.sv
logic/pad_mux.sv
logic/pinmux_top.sv
bench/tb_pinmux.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the pad mux testbench with Verilator, run it, check the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_pinmux -f tb.f -o tb_pinmux_sim \
  || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/tb_pinmux_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Test completed successfully" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation reported a failure"; exit 1; }
